// ==== core_pkg.sv ====
`default_nettype none

package core;

    typedef logic [31:0] word_t;    // Instructions, immediates and register data.
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;

    // Instruction formats as seen by the immediate builder.
    typedef enum logic [2:0] {
        R_FORMAT = 3'd0,
        I_FORMAT = 3'd1,
        S_FORMAT = 3'd2,
        B_FORMAT = 3'd3,
        U_FORMAT = 3'd4,
        J_FORMAT = 3'd5
    } formats_t;

    // RV32I major opcodes handled by this stage.
    typedef enum logic [6:0] {
        LUI_OP    = 7'b0110111,
        AUI_OP    = 7'b0010111,
        JAL_OP    = 7'b1101111,
        JALR_OP   = 7'b1100111,
        BRANCH_OP = 7'b1100011,
        LOAD_OP   = 7'b0000011,
        STORE_OP  = 7'b0100011,
        OPIMM_OP  = 7'b0010011,
        OP_OP     = 7'b0110011
    } opcode_t;

    // Arithmetic funct3 encodings.
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t SLLI_F3    = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t SRLI_SRAI  = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10  // Operand B straight through, for LUI.
    } alu_op_t;

endpackage

`default_nettype wire

// ==== decode_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Decoded control of the instruction currently in decode.
interface decode_if;

    core::formats_t format;
    core::reg_idx_t rs1;
    core::reg_idx_t rs2;
    core::reg_idx_t rd;
    core::alu_op_t  alu_op;
    logic           rd_we;
    logic           illegal;

    modport producer (
        output format, rs1, rs2, rd, alu_op, rd_we, illegal
    );

    modport consumer (
        input format, rs1, rs2, rd, alu_op, rd_we, illegal
    );

endinterface

`default_nettype wire

// ==== instr_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input  core::word_t instr_i,
    decode_if.producer  dec
);

    core::opcode_t opcode;
    core::funct3_t funct3;
    core::alu_op_t funct_op;   // ALU op implied by funct3 and bit 30.
    logic          sub_sel;

    assign opcode = core::opcode_t'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];

    assign dec.rs1 = instr_i[19:15];
    assign dec.rs2 = instr_i[24:20];
    assign dec.rd  = instr_i[11:7];

    // ADDI has no subtract form, bit 30 belongs to its immediate.
    assign sub_sel = instr_i[30] && (opcode == core::OP_OP);

    always_comb begin
        unique case (funct3)
            core::F3_ADD_SUB: funct_op = sub_sel ? core::ALU_SUB : core::ALU_ADD;
            core::SLLI_F3:    funct_op = core::ALU_SLL;
            core::F3_SLT:     funct_op = core::ALU_SLT;
            core::F3_SLTU:    funct_op = core::ALU_SLTU;
            core::F3_XOR:     funct_op = core::ALU_XOR;
            core::SRLI_SRAI:  funct_op = instr_i[30] ? core::ALU_SRA : core::ALU_SRL;
            core::F3_OR:      funct_op = core::ALU_OR;
            default:          funct_op = core::ALU_AND;
        endcase
    end

    always_comb begin
        dec.format  = core::R_FORMAT;
        dec.alu_op  = core::ALU_ADD;
        dec.rd_we   = 1'b0;
        dec.illegal = 1'b0;

        case (opcode)
            core::LUI_OP: begin
                dec.format = core::U_FORMAT;
                dec.alu_op = core::ALU_PASS_B;
                dec.rd_we  = 1'b1;
            end
            core::AUI_OP: begin
                dec.format = core::U_FORMAT;
                dec.rd_we  = 1'b1;
            end
            core::JAL_OP, core::JALR_OP: begin
                dec.format = core::J_FORMAT;
                dec.rd_we  = 1'b1;    // Link register.
            end
            core::BRANCH_OP: begin
                dec.format = core::B_FORMAT;
                dec.alu_op = core::ALU_SUB;    // Compare by subtraction.
            end
            core::LOAD_OP: begin
                dec.format = core::I_FORMAT;
                dec.rd_we  = 1'b1;
            end
            core::STORE_OP: begin
                dec.format = core::S_FORMAT;
            end
            core::OPIMM_OP: begin
                dec.format = core::I_FORMAT;
                dec.alu_op = funct_op;
                dec.rd_we  = 1'b1;
            end
            core::OP_OP: begin
                dec.format = core::R_FORMAT;
                dec.alu_op = funct_op;
                dec.rd_we  = 1'b1;
            end
            default: begin
                // Fence, system and anything unknown.
                dec.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== imm_generator.sv ====
`timescale 1ns/10ps
`default_nettype none

module imm_generator (
    input  core::word_t instr_i,
    decode_if.consumer  dec,
    output core::word_t imm_o
);

    core::opcode_t opcode;
    core::funct3_t funct3;
    logic          is_shift;

    assign opcode = core::opcode_t'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];

    // Loads share funct3 codes with the shifts, so check the opcode too.
    assign is_shift = (opcode == core::OPIMM_OP) &&
                      (funct3 == core::SLLI_F3 || funct3 == core::SRLI_SRAI);

    always_comb begin
        imm_o = '0;
        if (!dec.illegal) begin
            unique case (dec.format)
                core::I_FORMAT: begin
                    if (is_shift) begin
                        imm_o = {27'b0, instr_i[24:20]};    // Shift amount.
                    end else begin
                        imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
                    end
                end
                core::S_FORMAT: begin
                    imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                end
                core::B_FORMAT: begin
                    imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                             instr_i[30:25], instr_i[11:8], 1'b0};
                end
                core::U_FORMAT: begin
                    imm_o = {instr_i[31:12], 12'b0};
                end
                core::J_FORMAT: begin
                    if (opcode == core::JALR_OP) begin
                        imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
                    end else begin
                        imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                 instr_i[20], instr_i[30:21], 1'b0};
                    end
                end
                default: begin
                    imm_o = '0;    // R format has no immediate.
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic           clk_i,
    input  logic           arst_n_i,
    decode_if.consumer     dec,
    input  logic           wb_we_i,
    input  core::reg_idx_t wb_rd_i,
    input  core::word_t    wb_data_i,
    output core::word_t    rs1_data_o,
    output core::word_t    rs2_data_o
);

    core::word_t regs [1:31];    // x0 is not stored.

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // One read port with x0 and the writeback bypass.
    function automatic core::word_t read_port(core::reg_idx_t idx);
        core::word_t data;
        data = '0;
        if (idx != '0) begin
            if (wb_we_i && wb_rd_i == idx) begin
                data = wb_data_i;
            end else begin
                data = regs[idx];
            end
        end
        return data;
    endfunction

    assign rs1_data_o = read_port(dec.rs1);
    assign rs2_data_o = read_port(dec.rs2);

endmodule

`default_nettype wire

// ==== id_ex_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_ex_reg (
    input  logic           clk_i,
    input  logic           arst_n_i,
    input  logic           valid_i,
    input  logic           stall_i,
    input  logic           flush_i,
    decode_if.consumer     dec,
    input  core::word_t    imm_i,
    input  core::word_t    rs1_data_i,
    input  core::word_t    rs2_data_i,
    output logic           ex_valid_o,
    output core::word_t    ex_rs1_data_o,
    output core::word_t    ex_rs2_data_o,
    output core::word_t    ex_imm_o,
    output core::reg_idx_t ex_rd_o,
    output core::alu_op_t  ex_alu_op_o,
    output logic           ex_rd_we_o,
    output logic           ex_illegal_o
);

    // Control bits. Flush wins over stall.
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_o   <= 1'b0;
            ex_rd_we_o   <= 1'b0;
            ex_illegal_o <= 1'b0;
        end else if (flush_i) begin
            ex_valid_o   <= 1'b0;
            ex_rd_we_o   <= 1'b0;
            ex_illegal_o <= 1'b0;
        end else if (!stall_i) begin
            ex_valid_o   <= valid_i;
            ex_rd_we_o   <= valid_i & dec.rd_we;    // A bubble never writes.
            ex_illegal_o <= valid_i & dec.illegal;
        end
    end

    // Payload, only meaningful while ex_valid_o is set.
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            ex_rs1_data_o <= rs1_data_i;
            ex_rs2_data_o <= rs2_data_i;
            ex_imm_o      <= imm_i;
            ex_rd_o       <= dec.rd;
            ex_alu_op_o   <= dec.alu_op;
        end
    end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic           clk_i,
    input  logic           arst_n_i,
    // Fetch side.
    input  logic           valid_i,
    input  core::word_t    instr_i,
    // Pipeline control.
    input  logic           stall_i,
    input  logic           flush_i,
    // Writeback port.
    input  logic           wb_we_i,
    input  core::reg_idx_t wb_rd_i,
    input  core::word_t    wb_data_i,
    // To execute.
    output logic           ex_valid_o,
    output core::word_t    ex_rs1_data_o,
    output core::word_t    ex_rs2_data_o,
    output core::word_t    ex_imm_o,
    output core::reg_idx_t ex_rd_o,
    output core::alu_op_t  ex_alu_op_o,
    output logic           ex_rd_we_o,
    output logic           ex_illegal_o
);

    core::word_t imm;
    core::word_t rs1_data;
    core::word_t rs2_data;

    decode_if dec_bus ();

    instr_decoder decoder_i (
        .instr_i (instr_i),
        .dec     (dec_bus.producer)
    );

    imm_generator imm_gen_i (
        .instr_i (instr_i),
        .dec     (dec_bus.consumer),
        .imm_o   (imm)
    );

    reg_file reg_file_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .dec        (dec_bus.consumer),
        .wb_we_i    (wb_we_i),
        .wb_rd_i    (wb_rd_i),
        .wb_data_i  (wb_data_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    id_ex_reg id_ex_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .valid_i       (valid_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .dec           (dec_bus.consumer),
        .imm_i         (imm),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .ex_valid_o    (ex_valid_o),
        .ex_rs1_data_o (ex_rs1_data_o),
        .ex_rs2_data_o (ex_rs2_data_o),
        .ex_imm_o      (ex_imm_o),
        .ex_rd_o       (ex_rd_o),
        .ex_alu_op_o   (ex_alu_op_o),
        .ex_rd_we_o    (ex_rd_we_o),
        .ex_illegal_o  (ex_illegal_o)
    );

endmodule

`default_nettype wire

// ==== tb_decode_model.svh ====
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// Encoders follow the RV32I field layouts. R format goes through enc_i with {funct7, rs2}.
function automatic core::word_t enc_i(logic [6:0] op, core::reg_idx_t rd, core::funct3_t f3,
                                      core::reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic core::word_t enc_s(core::reg_idx_t rs1, core::reg_idx_t rs2,
                                      logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic core::word_t enc_b(core::reg_idx_t rs1, core::reg_idx_t rs2,
                                      logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic core::word_t enc_j(core::reg_idx_t rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// Sign extends the low bits of v.
function automatic core::word_t sext(core::word_t v, int bits);
    core::word_t sh;
    sh = v << (32 - bits);
    return $signed(sh) >>> (32 - bits);
endfunction

// Expected ALU op, write enable and illegal flag for one instruction word.
function automatic void expect_ctrl(input core::word_t w, output core::alu_op_t op,
                                    output logic we, output logic ill);
    op = core::ALU_ADD;
    we = 1'b1;
    ill = 1'b0;
    case (w[6:0])
        7'b0110111: op = core::ALU_PASS_B;    // LUI.
        7'b0010111, 7'b1101111, 7'b1100111, 7'b0000011: op = core::ALU_ADD;
        7'b0100011: we = 1'b0;
        7'b1100011: begin
            we = 1'b0;
            op = core::ALU_SUB;    // Branch compare.
        end
        7'b0010011, 7'b0110011: begin
            case (w[14:12])
                3'd0: op = (w[30] && w[5]) ? core::ALU_SUB : core::ALU_ADD;    // w[5] marks OP.
                3'd1: op = core::ALU_SLL;
                3'd2: op = core::ALU_SLT;
                3'd3: op = core::ALU_SLTU;
                3'd4: op = core::ALU_XOR;
                3'd5: op = w[30] ? core::ALU_SRA : core::ALU_SRL;
                3'd6: op = core::ALU_OR;
                default: op = core::ALU_AND;
            endcase
        end
        default: begin
            we = 1'b0;
            ill = 1'b1;
        end
    endcase
endfunction

`endif

// ==== tb_decode_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage;

    `include "tb_decode_model.svh"

    logic           clk, arst_n, valid, stall, flush, wb_we, ex_valid, ex_rd_we, ex_illegal;
    core::word_t    instr, wb_data, ex_rs1, ex_rs2, ex_imm;
    core::reg_idx_t wb_rd, ex_rd;
    core::alu_op_t  ex_alu_op;
    core::word_t    shadow [32];    // Expected register contents.
    int             errors, passed, failed;

    decode_stage dut_i (
        .clk_i (clk), .arst_n_i (arst_n), .valid_i (valid), .instr_i (instr),
        .stall_i (stall), .flush_i (flush), .wb_we_i (wb_we), .wb_rd_i (wb_rd),
        .wb_data_i (wb_data), .ex_valid_o (ex_valid), .ex_rs1_data_o (ex_rs1),
        .ex_rs2_data_o (ex_rs2), .ex_imm_o (ex_imm), .ex_rd_o (ex_rd),
        .ex_alu_op_o (ex_alu_op), .ex_rd_we_o (ex_rd_we), .ex_illegal_o (ex_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #200us;    // Far beyond the length of all tests.
        $display("Timeout: the tests did not finish within 200 us.");
        $display("Result: FAILED");
        $finish;
    end

    task automatic report_error(string msg);
        $display("FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic close_test(string name);
        $display("%s: %s with %0d errors", name, (errors == 0) ? "passed" : "failed", errors);
        if (errors == 0) begin
            passed++;
        end else begin
            failed++;
        end
        errors = 0;
    endtask

    // Presents one instruction and waits until it sits on the execute outputs.
    task automatic issue(core::word_t w);
        valid = 1'b1;
        instr = w;
        @(posedge clk);
        #1;
    endtask

    task automatic check_imm(core::word_t w, core::word_t exp);
        issue(w);
        if (ex_imm !== exp) begin
            report_error($sformatf("immediate of %h is %h, expected %h", w, ex_imm, exp));
        end
    endtask

    task automatic write_reg(core::reg_idx_t idx, core::word_t data);
        wb_we = 1'b1;
        wb_rd = idx;
        wb_data = data;
        @(posedge clk);
        #1;
        wb_we = 1'b0;
        if (idx != '0) begin
            shadow[idx] = data;
        end
    endtask

    task automatic read_regs(core::reg_idx_t a, core::reg_idx_t b);
        issue(enc_i(7'b0110011, 5'd1, 3'd0, a, {7'b0, b}));
        if (ex_rs1 !== shadow[a] || ex_rs2 !== shadow[b]) begin
            report_error($sformatf("x%0d/x%0d read %h/%h, expected %h/%h",
                                   a, b, ex_rs1, ex_rs2, shadow[a], shadow[b]));
        end
    endtask

    task automatic test_immediates();
        logic [31:0] r;
        logic [2:0]  f3;
        for (int i = 0; i < 200; i++) begin
            r = $urandom;
            // OPIMM avoids the shift funct3 values, loads take any.
            f3 = (!r[0] && r[13:12] == 2'b01) ? {r[14], 2'b00} : r[14:12];
            check_imm(enc_i(r[0] ? 7'b0000011 : 7'b0010011, r[11:7], f3, r[19:15], r[31:20]),
                      sext(32'(r[31:20]), 12));
            check_imm(enc_i(7'b0010011, r[11:7], r[1] ? 3'd1 : 3'd5, r[19:15],
                            {1'b0, r[2] & ~r[1], 5'b0, r[24:20]}), {27'b0, r[24:20]});
            check_imm(enc_s(r[19:15], r[24:20], r[31:20]), sext(32'(r[31:20]), 12));
            check_imm(enc_b(r[19:15], r[24:20], {r[31:20], 1'b0}),
                      sext(32'({r[31:20], 1'b0}), 13));
            check_imm({r[31:12], r[11:7], r[0] ? 7'b0110111 : 7'b0010111}, {r[31:12], 12'b0});
            check_imm(enc_j(r[11:7], {r[31:12], 1'b0}), sext(32'({r[31:12], 1'b0}), 21));
            check_imm(enc_i(7'b1100111, r[11:7], 3'd0, r[19:15], r[31:20]),
                      sext(32'(r[31:20]), 12));
            check_imm(enc_i(7'b0110011, r[11:7], r[14:12], r[19:15], {7'b0, r[24:20]}), 32'd0);
        end
    endtask

    task automatic test_decode();
        logic [6:0]    ops [13] = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011,
                                    7'b0000011, 7'b0100011, 7'b0010011, 7'b0110011, 7'b0001111,
                                    7'b1110011, 7'b0000000, 7'b1111111};
        core::word_t   w;
        core::alu_op_t op;
        logic          we, ill;
        for (int k = 0; k < 13; k++) begin
            for (int v = 0; v < 16; v++) begin
                w = $urandom;
                w[30] = v[0];
                w[14:12] = v[3:1];
                w[6:0] = ops[k];
                issue(w);
                expect_ctrl(w, op, we, ill);
                if ((!ill && ex_alu_op !== op) || ex_rd_we !== we || ex_illegal !== ill ||
                    ex_rd !== w[11:7]) begin
                    report_error($sformatf("control of %h: op %0d we %b illegal %b rd %0d",
                                           w, ex_alu_op, ex_rd_we, ex_illegal, ex_rd));
                end
            end
        end
    endtask

    task automatic test_regfile();
        core::reg_idx_t idx;
        core::word_t    data;
        for (int i = 0; i < 100; i++) begin
            idx = (i % 8 == 0) ? 5'd0 : 5'($urandom);
            write_reg(idx, $urandom);
            read_regs(idx, 5'($urandom));
        end
        for (int i = 0; i < 20; i++) begin
            idx = 5'($urandom);
            data = $urandom;
            wb_we = 1'b1;    // Write and read in the same cycle.
            wb_rd = idx;
            wb_data = data;
            if (idx != '0) begin
                shadow[idx] = data;
            end
            read_regs(idx, 5'd0);
            wb_we = 1'b0;
        end
    endtask

    task automatic test_pipeline();
        logic           v;
        core::word_t    imm, rs1, rs2;
        core::reg_idx_t rd;
        core::alu_op_t  op;
        instr = enc_i(7'b0010011, 5'd3, 3'd0, 5'd0, 12'h7ff);
        for (int i = 0; i < 30; i++) begin
            v = 1'($urandom);
            valid = v;
            @(posedge clk);
            #1;
            if (ex_valid !== v || ex_rd_we !== v) begin
                report_error($sformatf("ex_valid_o %b ex_rd_we_o %b after valid_i %b",
                                       ex_valid, ex_rd_we, v));
            end
        end
        issue(enc_i(7'b0010011, 5'd7, 3'd4, 5'd2, 12'h123));
        imm = ex_imm;
        rs1 = ex_rs1;
        rs2 = ex_rs2;
        rd = ex_rd;
        op = ex_alu_op;
        stall = 1'b1;
        for (int i = 0; i < 5; i++) begin
            issue($urandom);    // Not captured while stalled.
            if (ex_valid !== 1'b1 || ex_rd_we !== 1'b1 || ex_illegal !== 1'b0 || ex_imm !== imm ||
                ex_rs1 !== rs1 || ex_rs2 !== rs2 || ex_rd !== rd || ex_alu_op !== op) begin
                report_error("execute outputs changed during stall");
            end
        end
        flush = 1'b1;
        issue(enc_i(7'b0010011, 5'd4, 3'd0, 5'd0, 12'h001));
        if (ex_valid !== 1'b0 || ex_rd_we !== 1'b0) begin
            report_error("flush with stall high left ex_valid_o set");
        end
        stall = 1'b0;
        issue(enc_i(7'b0010011, 5'd4, 3'd0, 5'd0, 12'h001));
        if (ex_valid !== 1'b0 || ex_rd_we !== 1'b0) begin
            report_error("flush left ex_valid_o set");
        end
        flush = 1'b0;
        valid = 1'b0;
    endtask

    // Asserts reset for two cycles while instruction w sits in execute.
    task automatic pulse_reset(core::word_t w);
        issue(w);
        arst_n = 1'b0;
        #1;
        if (ex_valid !== 1'b0 || ex_rd_we !== 1'b0 || ex_illegal !== 1'b0) begin
            report_error($sformatf("outputs after %h did not drop at reset", w));
        end
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    task automatic test_reset();
        write_reg(5'd9, 32'hdeadbeef);
        pulse_reset(enc_i(7'b0010011, 5'd9, 3'd0, 5'd9, 12'h001));
        pulse_reset(enc_i(7'b0001111, 5'd0, 3'd0, 5'd0, 12'h0ff));    // Fence, so illegal.
        for (int k = 0; k < 32; k++) begin
            shadow[k] = '0;
        end
        for (int k = 0; k < 32; k++) begin
            read_regs(5'(k), 5'(31 - k));
        end
        valid = 1'b0;
    endtask

    initial begin
        void'($urandom(26));
        arst_n = 1'b0;
        valid = 1'b0;
        instr = '0;
        stall = 1'b0;
        flush = 1'b0;
        wb_we = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        errors = 0;
        passed = 0;
        failed = 0;
        for (int k = 0; k < 32; k++) begin
            shadow[k] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        test_immediates();
        close_test("immediates");
        test_decode();
        close_test("decode control");
        test_regfile();
        close_test("register file");
        test_pipeline();
        close_test("pipeline control");
        test_reset();
        close_test("reset");
        $display("Tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
core_pkg.sv
decode_if.sv
instr_decoder.sv
imm_generator.sv
reg_file.sv
id_ex_reg.sv
decode_stage.sv
tb_decode_stage.sv

// ==== Makefile ====
TOP = tb_decode_stage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module decode_stage
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f flist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir
